// ==== Bender.yml ====
package:
  name: node_io

sources:
  - verilog/node_io_pkg.sv
  - verilog/io_request_decode.sv
  - verilog/io_bridge_stage.sv
  - verilog/io_device_regs.sv
  - verilog/node_io_top.sv
  - target: test
    files:
      - verification/node_io_properties.sv
      - verification/node_io_tb.sv

// ==== flist.f ====
verilog/node_io_pkg.sv
verilog/io_request_decode.sv
verilog/io_bridge_stage.sv
verilog/io_device_regs.sv
verilog/node_io_top.sv
verification/node_io_properties.sv
verification/node_io_tb.sv

// ==== verification/node_io_properties.sv ====
`timescale 1ns/10ps

module node_io_properties #(
	parameter int RST_PULSE_CYCLES = 64
) (
	input logic        node_clk,
	input logic        rst,
	input logic        req_i,
	input logic        ack_i,
	input logic [15:0] node_rst_i
);

	int nz_cycles;	// cycles node_rst has been nonzero
	int fail_count = 0;	// failed assertion count

	always_ff @(posedge node_clk) begin
		if (rst || node_rst_i == '0)
			nz_cycles <= 0;
		else
			nz_cycles <= nz_cycles + 1;
	end

	// --------------------------------------------------
	// handshake order
	// --------------------------------------------------
	ack_needs_req: assert property (@(posedge node_clk) disable iff (rst)
		$rose(ack_i) |-> req_i)
		else begin
			fail_count++;
			$error("ack rose while req was low");
		end

	ack_falls_after_req: assert property (@(posedge node_clk) disable iff (rst)
		$fell(ack_i) |-> !$past(req_i))
		else begin
			fail_count++;
			$error("ack fell before req was released");
		end

	// reset pulse
	rst_clears_pulse: assert property (@(posedge node_clk)
		rst |=> (node_rst_i == '0))
		else begin
			fail_count++;
			$error("node reset lines not cleared by reset");
		end

	pulse_bounded: assert property (@(posedge node_clk) disable iff (rst)
		nz_cycles <= RST_PULSE_CYCLES + 2)
		else begin
			fail_count++;
			$error("node reset pulse too long");
		end

endmodule

bind node_io_top node_io_properties #(.RST_PULSE_CYCLES(RST_PULSE_CYCLES)) u_props (
	.node_clk, .rst, .req_i, .ack_i(ack_o), .node_rst_i(node_rst_o)
);

// ==== verification/node_io_tb.sv ====
`timescale 1ns/10ps

module node_io_tb;

	localparam int RST_PULSE   = 64;
	localparam int ACK_LIMIT   = 40;	// cycles per handshake phase
	localparam int RAND_SEED   = 32'h2160_5473;
	localparam logic [31:0] ADR_LED  = 32'hFD0F_FF00;
	localparam logic [31:0] ADR_RST  = 32'hFD0F_FC00;
	localparam logic [31:0] ADR_RAND = 32'hFD0F_FD00;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_WAIT} op_t;

	typedef struct {
		op_t         op;
		logic [31:0] adr;
		logic [3:0]  sel;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		logic        exp_err;
		logic [7:0]  exp_led;	// output state after the entry
		logic [15:0] exp_rst;
		logic [2:0]  exp_clk_en;
	} entry_t;

	logic        node_clk;
	logic        rst;
	logic        req;
	logic        we;
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] wdata;
	logic        ack_o;
	logic [31:0] rdata_o;
	logic        err_o;
	logic [7:0]  led_o;
	logic [15:0] node_rst_o;
	logic [2:0]  clk_en_o;

	entry_t stim_q[$];
	bit     table_ready;
	int     value_errors;
	int     protocol_errors;

	// reference model state
	logic [7:0]  m_led;
	logic [31:0] m_lfsr;
	logic [15:0] m_rst_field;
	logic [2:0]  m_clk_en;

	node_io_top #(.RST_PULSE_CYCLES(RST_PULSE)) dut_i (
		.node_clk, .rst,
		.req_i(req), .we_i(we), .adr_i(adr), .sel_i(sel), .wdata_i(wdata),
		.ack_o, .rdata_o, .err_o,
		.led_o, .node_rst_o, .clk_en_o
	);

	always #5 node_clk = ~node_clk;

	// --------------------------------------------------
	// checks and reference model
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name,
				expected, actual);
		end
	endtask

	task automatic report_fault(input string what);
		protocol_errors++;
		$display("handshake fault at %0t ns: %s", $time, what);
	endtask

	// galois step, shift right and fold taps on a 1 out
	function automatic logic [31:0] lfsr_next(input logic [31:0] v);
		return (v >> 1) ^ (v[0] ? LFSR_TAPS : 32'h0);
	endfunction

	function automatic entry_t predict(input entry_t e);
		entry_t      r;
		logic [23:0] page;
		r = e;
		page = e.adr[31:8];
		r.exp_data = '0;
		r.exp_err  = 1'b0;
		if (e.op == OP_WAIT)
			m_rst_field = '0;	// pulse has run out
		else if (page != ADR_LED[31:8] && page != ADR_RST[31:8] && page != ADR_RAND[31:8])
			r.exp_err = 1'b1;	// unmapped, no state change
		else if (e.op == OP_WR) begin
			if (page == ADR_LED[31:8]) begin
				if (e.sel[0])
					m_led = e.wdata[7:0];
			end
			else if (page == ADR_RST[31:8]) begin
				if (|e.sel[1:0]) begin
					m_rst_field = e.wdata[15:0];
					if (|e.wdata[5:4])
						m_clk_en[2] = 1'b1;	// node 2 group
				end
				if (|e.sel[3:2])
					m_clk_en = e.wdata[18:16];	// upper half last
			end
			else
				m_lfsr = (e.wdata == 32'h0) ? 32'h1 : e.wdata;
		end
		else begin
			if (page == ADR_LED[31:8])
				r.exp_data = {24'h0, m_led};
			else if (page == ADR_RST[31:8])
				r.exp_data = {13'h0, m_clk_en, m_rst_field};
			else begin
				r.exp_data = m_lfsr;
				m_lfsr = lfsr_next(m_lfsr);	// read steps the generator
			end
		end
		r.exp_led    = m_led;
		r.exp_rst    = m_rst_field;
		r.exp_clk_en = m_clk_en;
		return r;
	endfunction

	task automatic add_entry(input op_t op, input logic [31:0] a, input logic [3:0] s,
			input logic [31:0] d);
		entry_t e;
		e.op    = op;
		e.adr   = a;
		e.sel   = s;
		e.wdata = d;
		stim_q.push_back(e);
	endtask

	// --------------------------------------------------
	// four-phase host access
	// --------------------------------------------------
	task automatic run_access(input entry_t e, output logic [31:0] rd, output logic er);
		int waited;
		if (ack_o)
			report_fault("ack_o still high before a new request");
		@(posedge node_clk);
		req   <= 1'b1;
		we    <= (e.op == OP_WR);
		adr   <= e.adr;
		sel   <= e.sel;
		wdata <= e.wdata;
		waited = 0;
		@(negedge node_clk);
		while (!ack_o && waited < ACK_LIMIT) begin
			@(negedge node_clk);
			waited++;
		end
		if (!ack_o)
			report_fault("ack_o never rose for the request");
		rd = rdata_o;	// response held while ack is high
		er = err_o;
		@(posedge node_clk);
		req <= 1'b0;
		waited = 0;
		@(negedge node_clk);
		while (ack_o && waited < ACK_LIMIT) begin
			if (rdata_o !== rd || err_o !== er)
				report_fault("rdata_o or err_o changed while ack_o was high");
			@(negedge node_clk);
			waited++;
		end
		if (ack_o)
			report_fault("ack_o did not fall after req_i was released");
	endtask

	// --------------------------------------------------
	// stimulus table and main sequence
	// --------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic        er;
		int          seed_val;
		node_clk = 1'b0;
		rst   = 1'b1;
		req   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		sel   = '0;
		wdata = '0;
		seed_val = $urandom(RAND_SEED);
		m_led = '0;
		m_lfsr = 32'h1;
		m_rst_field = '0;
		m_clk_en = 3'b110;

		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);	// reset value 0006_0000
		add_entry(OP_WR, ADR_LED, 4'hF, $urandom);
		add_entry(OP_RD, ADR_LED, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_LED, 4'b1110, $urandom);	// byte 0 off
		add_entry(OP_RD, ADR_LED, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_LED, 4'b0001, $urandom);
		add_entry(OP_RD, ADR_LED, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_RST, 4'b0011, 32'h0000_0A03);
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		add_entry(OP_WAIT, ADR_RST, 4'h0, 32'h0);
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_RST, 4'b1100, 32'h0001_0000);	// clk_en to 001
		add_entry(OP_WR, ADR_RST, 4'b0001, 32'h0000_0010);	// node 2 sets bit 2
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		add_entry(OP_WAIT, ADR_RST, 4'h0, 32'h0);
		add_entry(OP_WR, ADR_RST, 4'hF, 32'h0003_0020);	// upper half wins
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		add_entry(OP_WAIT, ADR_RST, 4'h0, 32'h0);
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_RAND, 4'hF, $urandom);
		repeat (4) add_entry(OP_RD, ADR_RAND, 4'hF, 32'h0);
		add_entry(OP_WR, ADR_RAND, 4'hF, 32'h0);	// acts as seed 1
		repeat (3) add_entry(OP_RD, ADR_RAND, 4'hF, 32'h0);
		add_entry(OP_WR, 32'h1234_5600, 4'hF, $urandom);	// unmapped
		add_entry(OP_RD, 32'h0000_0000, 4'hF, 32'h0);
		add_entry(OP_RD, 32'hFD0F_FE00, 4'hF, 32'h0);
		add_entry(OP_RD, ADR_LED, 4'hF, 32'h0);
		add_entry(OP_RD, ADR_RAND, 4'hF, 32'h0);
		add_entry(OP_RD, ADR_RST, 4'hF, 32'h0);
		repeat (4) begin
			add_entry(OP_WR, ADR_LED, 4'($urandom), $urandom);
			add_entry(OP_RD, ADR_LED, 4'hF, 32'h0);
		end
		foreach (stim_q[i])
			stim_q[i] = predict(stim_q[i]);
		table_ready = 1'b1;

		repeat (2) @(posedge node_clk);
		rst <= 1'b0;
		@(negedge node_clk);
		check_value("led_o after reset", 32'h0, led_o);
		check_value("node_rst_o after reset", 32'h0, node_rst_o);
		check_value("clk_en_o after reset", 32'h6, clk_en_o);

		foreach (stim_q[i]) begin
			if (stim_q[i].op == OP_WAIT) begin
				repeat (RST_PULSE + 4) @(posedge node_clk);
				@(negedge node_clk);
			end
			else begin
				run_access(stim_q[i], rd, er);
				check_value($sformatf("rdata_o [%0d]", i), stim_q[i].exp_data, rd);
				check_value($sformatf("err_o [%0d]", i), stim_q[i].exp_err, er);
			end
			check_value($sformatf("led_o [%0d]", i), stim_q[i].exp_led, led_o);
			check_value($sformatf("node_rst_o [%0d]", i), stim_q[i].exp_rst, node_rst_o);
			check_value($sformatf("clk_en_o [%0d]", i), stim_q[i].exp_clk_en, clk_en_o);
		end

		$display("value errors: %0d, handshake errors: %0d, assertion errors: %0d",
			value_errors, protocol_errors, dut_i.u_props.fail_count);
		if (value_errors == 0 && protocol_errors == 0 && dut_i.u_props.fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog, sized from the table
	initial begin
		int limit_cycles;
		wait (table_ready);
		limit_cycles = stim_q.size() * 20 + RST_PULSE * 4;
		repeat (limit_cycles) @(posedge node_clk);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog/io_bridge_stage.sv ====
`timescale 1ns/10ps

module io_bridge_stage (
	input  logic                              node_clk,
	input  logic                              rst,
	// from the decoder
	input  logic                              dec_valid_i,
	input  logic                              dec_we_i,
	input  node_io_pkg::dev_sel_t             dec_target_i,
	input  logic [node_io_pkg::SEL_W-1:0]     dec_sel_i,
	input  logic [node_io_pkg::DATA_W-1:0]    dec_wdata_i,
	input  logic [1:0]                        dec_byte_adr_i,
	output logic                              dec_ready_o,
	// to the device registers
	output logic                              dev_valid_o,
	output logic                              dev_we_o,
	output node_io_pkg::dev_sel_t             dev_target_o,
	output logic [node_io_pkg::SEL_W-1:0]     dev_sel_o,
	output logic [node_io_pkg::DATA_W-1:0]    dev_wdata_o,
	output logic [1:0]                        dev_byte_adr_o
);

	logic full_q;	// entry occupied
	logic dev_take;
	logic load;

	// devices accept on the cycle the entry is valid
	assign dev_take    = full_q;
	assign dec_ready_o = ~full_q | dev_take;	// empty or draining
	assign load        = dec_valid_i & dec_ready_o;

	always_ff @(posedge node_clk) begin
		if (rst)
			full_q <= 1'b0;
		else if (load)
			full_q <= 1'b1;
		else if (dev_take)
			full_q <= 1'b0;
	end

	// entry payload
	always_ff @(posedge node_clk) begin
		if (load) begin
			dev_we_o       <= dec_we_i;
			dev_target_o   <= dec_target_i;
			dev_sel_o      <= dec_sel_i;
			dev_wdata_o    <= dec_wdata_i;
			dev_byte_adr_o <= dec_byte_adr_i;
		end
	end

	assign dev_valid_o = full_q;

endmodule

// ==== verilog/io_device_regs.sv ====
`timescale 1ns/10ps

module io_device_regs #(
	parameter int RST_PULSE_CYCLES = 64
) (
	input  logic                                 node_clk,
	input  logic                                 rst,
	input  logic                                 dev_valid_i,
	input  logic                                 dev_we_i,
	input  node_io_pkg::dev_sel_t                dev_target_i,
	input  logic [node_io_pkg::SEL_W-1:0]        dev_sel_i,
	input  logic [node_io_pkg::DATA_W-1:0]       dev_wdata_i,
	input  logic [1:0]                           dev_byte_adr_i,
	output logic                                 rsp_valid_o,
	output logic [node_io_pkg::DATA_W-1:0]       rsp_data_o,
	output logic                                 rsp_err_o,
	output logic [node_io_pkg::LED_W-1:0]        led_o,
	output logic [node_io_pkg::NODE_RST_W-1:0]   node_rst_o,
	output logic [node_io_pkg::CLK_EN_W-1:0]     clk_en_o
);

	localparam int CNT_W = $clog2(RST_PULSE_CYCLES + 1);
	localparam logic [CNT_W-1:0] PULSE_END = CNT_W'(RST_PULSE_CYCLES);

	node_io_pkg::rst_ctrl_word_t               wr_word;
	node_io_pkg::rst_ctrl_word_t               rst_rd;
	logic                                      word_hit;
	logic                                      led_wr;
	logic                                      rst_wr;
	logic                                      rand_wr;
	logic                                      rand_rd;
	logic [node_io_pkg::LED_W-1:0]             led_q;
	logic [node_io_pkg::NODE_RST_W-1:0]        rst_field_q;
	logic [CNT_W-1:0]                          rst_cnt_q;
	logic [node_io_pkg::CLK_EN_W-1:0]          clk_en_q;
	logic [node_io_pkg::DATA_W-1:0]            lfsr_q;
	logic [node_io_pkg::DATA_W-1:0]            lfsr_step;
	logic [node_io_pkg::DATA_W-1:0]            rd_data;
	logic                                      rd_err;

	assign wr_word.raw = dev_wdata_i;
	assign word_hit    = (dev_byte_adr_i == 2'd0);	// one register word per page

	// write / read strobes
	assign led_wr  = dev_valid_i & dev_we_i & word_hit & (dev_target_i == node_io_pkg::DEV_LED);
	assign rst_wr  = dev_valid_i & dev_we_i & word_hit & (dev_target_i == node_io_pkg::DEV_RST);
	assign rand_wr = dev_valid_i & dev_we_i & word_hit & (dev_target_i == node_io_pkg::DEV_RAND);
	assign rand_rd = dev_valid_i & ~dev_we_i & word_hit & (dev_target_i == node_io_pkg::DEV_RAND);

	// --------------------------------------------------
	// led latch
	// --------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst)
			led_q <= '0;
		else if (led_wr && dev_sel_i[0])
			led_q <= wr_word.raw[node_io_pkg::LED_W-1:0];
	end

	// --------------------------------------------------
	// node reset pulse and clock enables
	// --------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			rst_field_q <= '0;
			rst_cnt_q   <= PULSE_END;	// idle, no pulse running
			clk_en_q    <= node_io_pkg::CLK_EN_RESET;
		end
		else begin
			if (rst_cnt_q < PULSE_END)
				rst_cnt_q <= rst_cnt_q + 1'b1;
			else
				rst_field_q <= '0;	// pulse over
			if (rst_wr) begin
				if (|dev_sel_i[1:0]) begin
					rst_field_q <= wr_word.f.node_rst;
					rst_cnt_q   <= '0;	// restart pulse
					if (|wr_word.f.node_rst[5:4])
						clk_en_q[2] <= 1'b1;	// node 2 needs its clock
				end
				// upper half wins over the node 2 rule
				if (|dev_sel_i[3:2])
					clk_en_q <= wr_word.f.clk_en;
			end
		end
	end

	assign node_rst_o = (rst_cnt_q < PULSE_END) ? rst_field_q : '0;

	// readback word for the reset register
	always_comb begin
		rst_rd.f.unused   = '0;
		rst_rd.f.clk_en   = clk_en_q;
		rst_rd.f.node_rst = node_rst_o;
	end

	// --------------------------------------------------
	// random number generator
	// --------------------------------------------------
	// galois step, shift right and fold taps on a 1 out
	assign lfsr_step = {1'b0, lfsr_q[node_io_pkg::DATA_W-1:1]}
		^ (lfsr_q[0] ? node_io_pkg::RAND_TAPS : '0);

	always_ff @(posedge node_clk) begin
		if (rst)
			lfsr_q <= node_io_pkg::RAND_SEED_RESET;
		else if (rand_wr)
			lfsr_q <= (wr_word.raw == '0) ? node_io_pkg::RAND_SEED_RESET : wr_word.raw;
		else if (rand_rd)
			lfsr_q <= lfsr_step;	// advance after the read
	end

	// --------------------------------------------------
	// read mux and response
	// --------------------------------------------------
	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		if (!word_hit)
			rd_err = 1'b1;
		else begin
			case (dev_target_i)
			node_io_pkg::DEV_LED:	rd_data = {{(node_io_pkg::DATA_W-node_io_pkg::LED_W){1'b0}}, led_q};
			node_io_pkg::DEV_RST:	rd_data = rst_rd.raw;
			node_io_pkg::DEV_RAND:	rd_data = lfsr_q;	// value before the step
			default:	rd_err = 1'b1;
			endcase
		end
		if (dev_we_i || rd_err)
			rd_data = '0;	// writes and errors return nothing
	end

	always_ff @(posedge node_clk) begin
		if (rst)
			rsp_valid_o <= 1'b0;
		else
			rsp_valid_o <= dev_valid_i;	// one cycle behind the request
	end

	always_ff @(posedge node_clk) begin
		if (dev_valid_i) begin
			rsp_data_o <= rd_data;
			rsp_err_o  <= rd_err;
		end
	end

	assign led_o    = led_q;
	assign clk_en_o = clk_en_q;

endmodule

// ==== verilog/io_request_decode.sv ====
`timescale 1ns/10ps

module io_request_decode (
	input  logic                              node_clk,
	input  logic                              rst,
	// host port, four-phase req/ack
	input  logic                              req_i,
	input  logic                              we_i,
	input  logic [node_io_pkg::ADR_W-1:0]     adr_i,
	input  logic [node_io_pkg::SEL_W-1:0]     sel_i,
	input  logic [node_io_pkg::DATA_W-1:0]    wdata_i,
	output logic                              ack_o,
	output logic [node_io_pkg::DATA_W-1:0]    rdata_o,
	output logic                              err_o,
	// request toward the bridge
	output logic                              dec_valid_o,
	output logic                              dec_we_o,
	output node_io_pkg::dev_sel_t             dec_target_o,
	output logic [node_io_pkg::SEL_W-1:0]     dec_sel_o,
	output logic [node_io_pkg::DATA_W-1:0]    dec_wdata_o,
	output logic [1:0]                        dec_byte_adr_o,
	input  logic                              dec_ready_i,
	// response from the devices
	input  logic                              rsp_valid_i,
	input  logic [node_io_pkg::DATA_W-1:0]    rsp_data_i,
	input  logic                              rsp_err_i
);

	// slave fsm states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_ISSUE = 2'd1;	// waiting for bridge to take it
	localparam logic [1:0] ST_WAIT  = 2'd2;	// in flight to devices
	localparam logic [1:0] ST_ACK   = 2'd3;	// ack held until req drops

	logic [1:0]                        state_q;
	node_io_pkg::dev_sel_t             target_d;
	logic                              we_q;
	node_io_pkg::dev_sel_t             target_q;
	logic [node_io_pkg::SEL_W-1:0]     sel_q;
	logic [node_io_pkg::DATA_W-1:0]    wdata_q;
	logic [1:0]                        byte_adr_q;
	logic [node_io_pkg::DATA_W-1:0]    rdata_q;
	logic                              err_q;
	logic                              start;

	// --------------------------------------------------
	// page decode
	// --------------------------------------------------
	always_comb begin
		if (adr_i[31:8] == node_io_pkg::PAGE_ADR_LED)
			target_d = node_io_pkg::DEV_LED;
		else if (adr_i[31:8] == node_io_pkg::PAGE_ADR_RST)
			target_d = node_io_pkg::DEV_RST;
		else if (adr_i[31:8] == node_io_pkg::PAGE_ADR_RAND)
			target_d = node_io_pkg::DEV_RAND;
		else
			target_d = node_io_pkg::DEV_NONE;	// completes with err
	end

	assign start = (state_q == ST_IDLE) && req_i;

	// --------------------------------------------------
	// handshake fsm
	// --------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst)
			state_q <= ST_IDLE;
		else begin
			case (state_q)
			ST_IDLE:	if (req_i) state_q <= ST_ISSUE;
			ST_ISSUE:	if (dec_ready_i) state_q <= ST_WAIT;
			ST_WAIT:	if (rsp_valid_i) state_q <= ST_ACK;
			ST_ACK:		if (!req_i) state_q <= ST_IDLE;	// host released
			default:	state_q <= ST_IDLE;
			endcase
		end
	end

	// request and response capture
	always_ff @(posedge node_clk) begin
		if (start) begin
			we_q       <= we_i;
			target_q   <= target_d;
			sel_q      <= sel_i;
			wdata_q    <= wdata_i;
			byte_adr_q <= adr_i[3:2];	// word within the page
		end
		if ((state_q == ST_WAIT) && rsp_valid_i) begin
			rdata_q <= rsp_data_i;	// held for the whole ack phase
			err_q   <= rsp_err_i;
		end
	end

	assign dec_valid_o    = (state_q == ST_ISSUE);
	assign dec_we_o       = we_q;
	assign dec_target_o   = target_q;
	assign dec_sel_o      = sel_q;
	assign dec_wdata_o    = wdata_q;
	assign dec_byte_adr_o = byte_adr_q;

	assign ack_o   = (state_q == ST_ACK);
	assign rdata_o = rdata_q;
	assign err_o   = err_q;

endmodule

// ==== verilog/node_io_pkg.sv ====
package node_io_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------
	localparam int DATA_W = 32;
	localparam int ADR_W  = 32;
	localparam int SEL_W  = 4;		// one enable per byte lane
	localparam int PAGE_W = 24;	// address bits 31..8 pick the page

	// device widths
	localparam int LED_W      = 8;
	localparam int NODE_RST_W = 16;	// two reset lines per node
	localparam int CLK_EN_W   = 3;

	// --------------------------------------------------
	// i/o page map
	// --------------------------------------------------
	localparam logic [PAGE_W-1:0] PAGE_ADR_LED  = 24'hFD0FFF;
	localparam logic [PAGE_W-1:0] PAGE_ADR_RST  = 24'hFD0FFC;
	localparam logic [PAGE_W-1:0] PAGE_ADR_RAND = 24'hFD0FFD;

	// reset defaults
	localparam logic [CLK_EN_W-1:0] CLK_EN_RESET = 3'b110;	// node 0 gated off
	localparam logic [DATA_W-1:0] RAND_SEED_RESET = 32'h0000_0001;

	// galois feedback mask, bits 31, 21, 1, 0
	localparam logic [DATA_W-1:0] RAND_TAPS = 32'h8020_0003;

	// selected device behind the bridge
	typedef enum logic [1:0] {
		DEV_LED  = 2'd0,
		DEV_RST  = 2'd1,
		DEV_RAND = 2'd2,
		DEV_NONE = 2'd3	// no register at this address
	} dev_sel_t;

	// --------------------------------------------------
	// reset control word
	// --------------------------------------------------
	// the reset register splits the word into fields,
	// led and random registers see it as a plain word
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [12:0]           unused;
			logic [CLK_EN_W-1:0]   clk_en;		// bits 18..16
			logic [NODE_RST_W-1:0] node_rst;	// bits 5..4 are node 2
		} f;
	} rst_ctrl_word_t;

endpackage

// ==== verilog/node_io_top.sv ====
`timescale 1ns/10ps

module node_io_top #(
	parameter int RST_PULSE_CYCLES = 64	// node reset pulse length
) (
	input  logic                                 node_clk,
	input  logic                                 rst,
	// host port
	input  logic                                 req_i,
	input  logic                                 we_i,
	input  logic [node_io_pkg::ADR_W-1:0]        adr_i,
	input  logic [node_io_pkg::SEL_W-1:0]        sel_i,
	input  logic [node_io_pkg::DATA_W-1:0]       wdata_i,
	output logic                                 ack_o,
	output logic [node_io_pkg::DATA_W-1:0]       rdata_o,
	output logic                                 err_o,
	// board and node side
	output logic [node_io_pkg::LED_W-1:0]        led_o,
	output logic [node_io_pkg::NODE_RST_W-1:0]   node_rst_o,
	output logic [node_io_pkg::CLK_EN_W-1:0]     clk_en_o
);

	// decoder to bridge
	logic                              dec_valid;
	logic                              dec_ready;
	logic                              dec_we;
	node_io_pkg::dev_sel_t             dec_target;
	logic [node_io_pkg::SEL_W-1:0]     dec_sel;
	logic [node_io_pkg::DATA_W-1:0]    dec_wdata;
	logic [1:0]                        dec_byte_adr;

	// bridge to devices
	logic                              dev_valid;
	logic                              dev_we;
	node_io_pkg::dev_sel_t             dev_target;
	logic [node_io_pkg::SEL_W-1:0]     dev_sel;
	logic [node_io_pkg::DATA_W-1:0]    dev_wdata;
	logic [1:0]                        dev_byte_adr;

	// devices back to decoder
	logic                              rsp_valid;
	logic [node_io_pkg::DATA_W-1:0]    rsp_data;
	logic                              rsp_err;

	io_request_decode u_decode (
		.node_clk, .rst,
		.req_i, .we_i, .adr_i, .sel_i, .wdata_i,
		.ack_o, .rdata_o, .err_o,
		.dec_valid_o(dec_valid), .dec_we_o(dec_we), .dec_target_o(dec_target),
		.dec_sel_o(dec_sel), .dec_wdata_o(dec_wdata), .dec_byte_adr_o(dec_byte_adr),
		.dec_ready_i(dec_ready),
		.rsp_valid_i(rsp_valid), .rsp_data_i(rsp_data), .rsp_err_i(rsp_err)
	);

	io_bridge_stage u_bridge (
		.node_clk, .rst,
		.dec_valid_i(dec_valid), .dec_we_i(dec_we), .dec_target_i(dec_target),
		.dec_sel_i(dec_sel), .dec_wdata_i(dec_wdata), .dec_byte_adr_i(dec_byte_adr),
		.dec_ready_o(dec_ready),
		.dev_valid_o(dev_valid), .dev_we_o(dev_we), .dev_target_o(dev_target),
		.dev_sel_o(dev_sel), .dev_wdata_o(dev_wdata), .dev_byte_adr_o(dev_byte_adr)
	);

	io_device_regs #(.RST_PULSE_CYCLES(RST_PULSE_CYCLES)) u_regs (
		.node_clk, .rst,
		.dev_valid_i(dev_valid), .dev_we_i(dev_we), .dev_target_i(dev_target),
		.dev_sel_i(dev_sel), .dev_wdata_i(dev_wdata), .dev_byte_adr_i(dev_byte_adr),
		.rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data), .rsp_err_o(rsp_err),
		.led_o, .node_rst_o, .clk_en_o
	);

endmodule
